/* verilog/backend_config.svh */
// sizing for the back end; BE_TAG_W must stay equal to log2 of BE_ROB_DEPTH
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// operand and result width
`define BE_XLEN 64

// entries in each issue queue
`define BE_ISSUE_DEPTH 4

// reorder window slots, one per micro-op in flight
`define BE_ROB_DEPTH 8

// sequence tag, indexes the reorder window directly
`define BE_TAG_W 3

// destination register index
`define BE_RD_W 5

`endif

/* verilog/backend_pkg.sv */
// shared back-end types; field widths follow the config header, op encodings are fixed
`default_nettype none
`include "backend_config.svh"

package backend_pkg;

	typedef enum logic {
		UNIT_ADDER,
		UNIT_LOGCMP
	} unit_t;

	// encodings shared with the reference model
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_SLTU = 3'd6
	} op_t;

	// operands already read
	typedef struct packed {
		unit_t                unit;
		op_t                  op;
		logic [`BE_RD_W-1:0]  rd;
		logic [`BE_XLEN-1:0]  src1;
		logic [`BE_XLEN-1:0]  src2;
	} micro_op_t;

	typedef struct packed {
		logic [`BE_TAG_W-1:0] tag;
		op_t                  op;
		logic [`BE_RD_W-1:0]  rd;
		logic [`BE_XLEN-1:0]  src1;
		logic [`BE_XLEN-1:0]  src2;
	} issue_t;

	typedef struct packed {
		logic [`BE_TAG_W-1:0] tag;
		logic [`BE_RD_W-1:0]  rd;
		logic [`BE_XLEN-1:0]  data;
	} result_t;

	typedef struct packed {
		logic [`BE_RD_W-1:0]  rd;
		logic [`BE_XLEN-1:0]  data;
	} retire_t;

endpackage

`default_nettype wire

/* verilog/issue_fifo.sv */
// fall-through queue; push while full and pop while empty are not guarded here
`timescale 1ns/10ps
`default_nettype none
`include "backend_config.svh"

module issue_fifo #(
	parameter type T = logic [7:0]
) (
	input  logic CLK,
	input  logic i_rst_n,
	input  logic i_push,
	input  T     i_data,
	input  logic i_pop,
	output T     o_data,
	output logic o_full,
	output logic o_empty
);

	localparam int DEPTH = `BE_ISSUE_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);
	localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

	T mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;

	// head always visible
	assign o_data = mem[rd_ptr];
	assign o_full = (count == FULL_CNT);
	assign o_empty = (count == '0);

	always_ff @(posedge CLK) begin
		if (i_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
			end
			if (i_push && !i_pop) begin
				count <= count + 1'b1;
			end else if (i_pop && !i_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/dispatch.sv */
// in-order dispatch, one micro-op per cycle; the tag counter tracks the reorder tail
`timescale 1ns/10ps
`default_nettype none
`include "backend_config.svh"

module dispatch (
	input  logic                   CLK,
	input  logic                   i_rst_n,
	input  backend_pkg::micro_op_t i_instr,
	input  logic                   i_instr_empty,
	input  logic                   i_adder_full,
	input  logic                   i_logcmp_full,
	input  logic                   i_rob_full,
	output logic                   o_instr_pop,
	output logic                   o_adder_push,
	output logic                   o_logcmp_push,
	output backend_pkg::issue_t    o_issue,
	output logic                   o_alloc
);
	import backend_pkg::*;

	localparam logic [`BE_TAG_W-1:0] LAST_TAG = `BE_TAG_W'(`BE_ROB_DEPTH - 1);

	logic [`BE_TAG_W-1:0] tag_q;
	logic to_adder;
	logic target_full;

	assign to_adder = (i_instr.unit == UNIT_ADDER);
	assign target_full = to_adder ? i_adder_full : i_logcmp_full;

	// stall on empty input, full target queue or full window
	assign o_instr_pop = !i_instr_empty && !target_full && !i_rob_full;
	assign o_adder_push = o_instr_pop && to_adder;
	assign o_logcmp_push = o_instr_pop && !to_adder;
	assign o_alloc = o_instr_pop;

	always_comb begin
		o_issue.tag = tag_q;
		o_issue.op = i_instr.op;
		o_issue.rd = i_instr.rd;
		o_issue.src1 = i_instr.src1;
		o_issue.src2 = i_instr.src2;
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			tag_q <= '0;
		end else if (o_instr_pop) begin
			tag_q <= (tag_q == LAST_TAG) ? '0 : tag_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/adder_unit.sv */
// single-cycle add/sub; takes every queued entry, ops other than sub are added
`timescale 1ns/10ps
`default_nettype none

module adder_unit (
	input  logic                 CLK,
	input  logic                 i_rst_n,
	input  backend_pkg::issue_t  i_entry,
	input  logic                 i_empty,
	output logic                 o_pop,
	output logic                 o_valid,
	output backend_pkg::result_t o_result
);
	import backend_pkg::*;

	// no stall, the window slot is already reserved
	assign o_pop = !i_empty;

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= o_pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_pop) begin
			o_result.tag <= i_entry.tag;
			o_result.rd <= i_entry.rd;
			if (i_entry.op == OP_SUB) begin
				o_result.data <= i_entry.src1 - i_entry.src2;
			end else begin
				o_result.data <= i_entry.src1 + i_entry.src2;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/logcmp_unit.sv */
// two-stage logic/compare pipe, fully pipelined; unknown ops give zero
`timescale 1ns/10ps
`default_nettype none
`include "backend_config.svh"

module logcmp_unit (
	input  logic                 CLK,
	input  logic                 i_rst_n,
	input  backend_pkg::issue_t  i_entry,
	input  logic                 i_empty,
	output logic                 o_pop,
	output logic                 o_valid,
	output backend_pkg::result_t o_result
);
	import backend_pkg::*;

	logic s1_valid;
	issue_t s1_entry;
	logic [`BE_XLEN-1:0] res;

	assign o_pop = !i_empty;

	// stage one, capture operands
	always_ff @(posedge CLK) begin
		if (o_pop) begin
			s1_entry <= i_entry;
		end
	end

	always_comb begin
		case (s1_entry.op)
			OP_AND:  res = s1_entry.src1 & s1_entry.src2;
			OP_OR:   res = s1_entry.src1 | s1_entry.src2;
			OP_XOR:  res = s1_entry.src1 ^ s1_entry.src2;
			OP_SLT:  res = {{(`BE_XLEN-1){1'b0}}, $signed(s1_entry.src1) < $signed(s1_entry.src2)};
			OP_SLTU: res = {{(`BE_XLEN-1){1'b0}}, s1_entry.src1 < s1_entry.src2};
			default: res = '0;
		endcase
	end

	// stage two, register the result
	always_ff @(posedge CLK) begin
		if (s1_valid) begin
			o_result.tag <= s1_entry.tag;
			o_result.rd <= s1_entry.rd;
			o_result.data <= res;
		end
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			s1_valid <= o_pop;
			o_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* verilog/reorder_commit.sv */
// reorder window indexed by tag; tags must be allocated in order, at most one retire per cycle
`timescale 1ns/10ps
`default_nettype none
`include "backend_config.svh"

module reorder_commit (
	input  logic                 CLK,
	input  logic                 i_rst_n,
	input  logic                 i_alloc,
	input  logic                 i_adder_valid,
	input  backend_pkg::result_t i_adder_result,
	input  logic                 i_logcmp_valid,
	input  backend_pkg::result_t i_logcmp_result,
	output logic                 o_rob_full,
	output logic                 o_retire_valid,
	output backend_pkg::retire_t o_retire
);
	import backend_pkg::*;

	localparam int DEPTH = `BE_ROB_DEPTH;
	localparam logic [`BE_TAG_W-1:0] LAST_TAG = `BE_TAG_W'(DEPTH - 1);
	localparam logic [`BE_TAG_W:0] FULL_CNT = (`BE_TAG_W + 1)'(DEPTH);

	logic [`BE_XLEN-1:0] data_mem [DEPTH];
	logic [`BE_RD_W-1:0] rd_mem [DEPTH];
	logic [DEPTH-1:0] done_q;
	logic [`BE_TAG_W-1:0] head_q;
	logic [`BE_TAG_W:0] count_q;
	logic head_done;

	assign head_done = done_q[head_q];
	assign o_rob_full = (count_q == FULL_CNT);

	// both units may write in the same cycle
	always_ff @(posedge CLK) begin
		if (i_adder_valid) begin
			data_mem[i_adder_result.tag] <= i_adder_result.data;
			rd_mem[i_adder_result.tag] <= i_adder_result.rd;
		end
		if (i_logcmp_valid) begin
			data_mem[i_logcmp_result.tag] <= i_logcmp_result.data;
			rd_mem[i_logcmp_result.tag] <= i_logcmp_result.rd;
		end
		if (head_done) begin
			o_retire.rd <= rd_mem[head_q];
			o_retire.data <= data_mem[head_q];
		end
	end

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			done_q <= '0;
			head_q <= '0;
			count_q <= '0;
			o_retire_valid <= 1'b0;
		end else begin
			o_retire_valid <= head_done;
			if (head_done) begin
				done_q[head_q] <= 1'b0;
				head_q <= (head_q == LAST_TAG) ? '0 : head_q + 1'b1;
			end
			// a slot is never rewritten while still at the head
			if (i_adder_valid) begin
				done_q[i_adder_result.tag] <= 1'b1;
			end
			if (i_logcmp_valid) begin
				done_q[i_logcmp_result.tag] <= 1'b1;
			end
			if (i_alloc && !head_done) begin
				count_q <= count_q + 1'b1;
			end else if (head_done && !i_alloc) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/backend.sv */
// integer back end top; in-order retire, no output back-pressure, no flush
`timescale 1ns/10ps
`default_nettype none

module backend (
	input  logic                   CLK,
	input  logic                   i_rst_n,
	input  backend_pkg::micro_op_t i_instr,
	input  logic                   i_instr_empty,
	output logic                   o_instr_pop,
	output logic                   o_retire_valid,
	output backend_pkg::retire_t   o_retire
);
	import backend_pkg::*;

	issue_t issue;
	issue_t adder_head;
	issue_t logcmp_head;
	result_t adder_result;
	result_t logcmp_result;
	logic adder_push, adder_pop, adder_full, adder_empty;
	logic logcmp_push, logcmp_pop, logcmp_full, logcmp_empty;
	logic adder_valid, logcmp_valid;
	logic alloc, rob_full;

	dispatch i_dispatch (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_instr(i_instr), .i_instr_empty(i_instr_empty),
		.i_adder_full(adder_full), .i_logcmp_full(logcmp_full), .i_rob_full(rob_full),
		.o_instr_pop(o_instr_pop), .o_adder_push(adder_push), .o_logcmp_push(logcmp_push),
		.o_issue(issue), .o_alloc(alloc)
	);

	issue_fifo #(.T(issue_t)) i_adder_fifo (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_push(adder_push), .i_data(issue),
		.i_pop(adder_pop), .o_data(adder_head), .o_full(adder_full), .o_empty(adder_empty)
	);

	issue_fifo #(.T(issue_t)) i_logcmp_fifo (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_push(logcmp_push), .i_data(issue),
		.i_pop(logcmp_pop), .o_data(logcmp_head), .o_full(logcmp_full), .o_empty(logcmp_empty)
	);

	adder_unit i_adder_unit (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_entry(adder_head), .i_empty(adder_empty),
		.o_pop(adder_pop), .o_valid(adder_valid), .o_result(adder_result)
	);

	logcmp_unit i_logcmp_unit (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_entry(logcmp_head), .i_empty(logcmp_empty),
		.o_pop(logcmp_pop), .o_valid(logcmp_valid), .o_result(logcmp_result)
	);

	reorder_commit i_reorder_commit (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_alloc(alloc),
		.i_adder_valid(adder_valid), .i_adder_result(adder_result),
		.i_logcmp_valid(logcmp_valid), .i_logcmp_result(logcmp_result),
		.o_rob_full(rob_full), .o_retire_valid(o_retire_valid), .o_retire(o_retire)
	);

endmodule

`default_nettype wire

/* testbench/backend_chk.sv */
// handshake and unit latency assertions for the back end top, bound in below; checks start after reset
`timescale 1ns/10ps
`default_nettype none

module backend_chk (
	input logic CLK,
	input logic i_rst_n,
	input logic i_instr_empty,
	input logic i_instr_pop,
	input logic i_adder_pop,
	input logic i_adder_valid,
	input logic i_logcmp_pop,
	input logic i_logcmp_valid,
	input logic i_retire_valid
);

	a_instr_pop: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_instr_pop |-> !i_instr_empty)
		else $error("instruction queue popped while empty");

	// adder result one cycle after its pop
	a_adder_latency: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_adder_pop |=> i_adder_valid)
		else $error("adder result missing one cycle after pop");

	// logcmp result two cycles after its pop
	a_logcmp_latency: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_logcmp_pop |=> ##1 i_logcmp_valid)
		else $error("logcmp result missing two cycles after pop");

	// first cycle out of reset is idle
	a_retire_after_reset: assert property (@(posedge CLK) !i_rst_n |=> !i_retire_valid)
		else $error("retire in the first cycle after reset");

endmodule

bind backend backend_chk i_backend_chk (
	.CLK(CLK),
	.i_rst_n(i_rst_n),
	.i_instr_empty(i_instr_empty),
	.i_instr_pop(o_instr_pop),
	.i_adder_pop(adder_pop),
	.i_adder_valid(adder_valid),
	.i_logcmp_pop(logcmp_pop),
	.i_logcmp_valid(logcmp_valid),
	.i_retire_valid(o_retire_valid)
);

`default_nettype wire

/* testbench/backend_tb.sv */
// self-checking testbench; every micro-op must retire in order, a timeout ends the run early
`timescale 1ns/10ps
`default_nettype none
`include "backend_config.svh"

module backend_tb;
	import backend_pkg::*;

	localparam int MAX_OPS = 256;

	logic CLK;
	logic i_rst_n;
	micro_op_t i_instr;
	logic i_instr_empty;
	logic o_instr_pop;
	logic o_retire_valid;
	retire_t o_retire;

	micro_op_t stream [MAX_OPS];
	retire_t exp_q [$];
	int wr_idx;
	int rd_idx;
	int supplied;
	int pop_cnt;
	int retired_cnt;
	int err_cnt;
	int tests_run;
	int tests_failed;
	logic gap_mode;
	logic timed_out;
	logic [31:0] lfsr_state;

	backend i_backend (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [`BE_XLEN-1:0] expected_value(input op_t op,
			input logic [`BE_XLEN-1:0] a, input logic [`BE_XLEN-1:0] b);
		logic lt;
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a + ~b + `BE_XLEN'(1);
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT: begin
				// differing signs decide the compare on their own
				lt = (a[`BE_XLEN-1] != b[`BE_XLEN-1]) ? a[`BE_XLEN-1] : (a < b);
				return {{(`BE_XLEN-1){1'b0}}, lt};
			end
			OP_SLTU: return {{(`BE_XLEN-1){1'b0}}, a < b};
			default: return '0;
		endcase
	endfunction

	function automatic op_t adder_op();
		return (rand_bits(1) != 0) ? OP_SUB : OP_ADD;
	endfunction

	function automatic op_t logcmp_op();
		logic [2:0] r;
		r = 3'(rand_bits(3) % 5);
		return op_t'(3'(OP_AND) + r);
	endfunction

	// instruction queue model, advances on each pop
	always @(posedge CLK) begin
		int nxt;
		int gap_left;
		nxt = rd_idx;
		if (o_instr_pop) begin
			nxt = rd_idx + 1;
			pop_cnt <= pop_cnt + 1;
		end
		if (gap_mode && o_instr_pop) begin
			gap_left = int'(rand_bits(3));
		end else if (gap_left > 0) begin
			gap_left = gap_left - 1;
		end
		rd_idx <= nxt;
		i_instr <= stream[nxt];
		i_instr_empty <= (nxt >= supplied) || (gap_left > 0);
	end

	// in-order comparison of every retire
	always @(posedge CLK) begin
		retire_t want;
		if (i_rst_n && o_retire_valid) begin
			retired_cnt <= retired_cnt + 1;
			if (exp_q.size() == 0) begin
				$display("retire at %0t with no micro-op outstanding", $time);
				err_cnt++;
			end else begin
				want = exp_q.pop_front();
				if (o_retire.rd !== want.rd) begin
					$display("** Error at %0t: o_retire.rd = %0d, expected %0d",
						$time, o_retire.rd, want.rd);
					err_cnt++;
				end
				if (o_retire.data !== want.data) begin
					$display("** Error at %0t: o_retire.data = %h, expected %h",
						$time, o_retire.data, want.data);
					err_cnt++;
				end
			end
		end
	end

	task automatic add_op(input unit_t unit, input op_t op, input int sign_mode);
		micro_op_t m;
		retire_t r;
		m.unit = unit;
		m.op = op;
		m.rd = `BE_RD_W'(rand_bits(`BE_RD_W));
		m.src1 = rand_bits(`BE_XLEN);
		m.src2 = rand_bits(`BE_XLEN);
		// sign_mode 1 makes only src1 negative, 2 makes only src2 negative
		if (sign_mode != 0) begin
			m.src1[`BE_XLEN-1] = (sign_mode == 1);
			m.src2[`BE_XLEN-1] = (sign_mode == 2);
		end
		stream[wr_idx] = m;
		wr_idx++;
		r.rd = m.rd;
		r.data = expected_value(op, m.src1, m.src2);
		exp_q.push_back(r);
	endtask

	task automatic report_test(input string name, input int base_err);
		tests_run++;
		if (err_cnt != base_err) begin
			tests_failed++;
		end
		$display("test %s: %s, %0d errors", name,
			(err_cnt == base_err) ? "ok" : "failed", err_cnt - base_err);
	endtask

	task automatic check_idle();
		int base_err;
		base_err = err_cnt;
		repeat (20) begin
			@(posedge CLK);
			if (o_retire_valid !== 1'b0) begin
				$display("** Error at %0t: o_retire_valid = %b, expected 0", $time, o_retire_valid);
				err_cnt++;
			end
		end
		@(negedge CLK);
		report_test("idle after reset", base_err);
	endtask

	// kind 0 adder, 1 logcmp, 2 interleaved, 3 burst, 4 gaps
	task automatic run_test(input string name, input int kind, input int n);
		int i;
		int base_err;
		int base_ret;
		int base_pop;
		int wait_cyc;
		base_err = err_cnt;
		base_ret = retired_cnt;
		base_pop = pop_cnt;
		gap_mode <= (kind == 4);
		for (i = 0; i < n; i++) begin
			if (kind == 1 && i < 4) begin
				// opposite signs, where signed and unsigned compares disagree
				add_op(UNIT_LOGCMP, (i % 2 != 0) ? OP_SLTU : OP_SLT, (i < 2) ? 1 : 2);
			end else if (kind == 0) begin
				add_op(UNIT_ADDER, adder_op(), 0);
			end else if (kind == 1 || (kind == 2 && i % 4 < 2)) begin
				add_op(UNIT_LOGCMP, logcmp_op(), 0);
			end else if (kind == 2 || rand_bits(1) != 0) begin
				add_op(UNIT_ADDER, adder_op(), 0);
			end else begin
				add_op(UNIT_LOGCMP, logcmp_op(), 0);
			end
		end
		supplied <= wr_idx;
		wait_cyc = 0;
		while (retired_cnt - base_ret < n && wait_cyc < 40 * n + 100) begin
			@(posedge CLK);
			wait_cyc++;
		end
		if (retired_cnt - base_ret < n) begin
			$display("test %s timed out with %0d of %0d micro-ops retired",
				name, retired_cnt - base_ret, n);
			timed_out = 1'b1;
			err_cnt++;
		end else begin
			// quiet stretch, nothing more may leave
			repeat (20) @(posedge CLK);
			@(negedge CLK);
			if (pop_cnt - base_pop != n) begin
				$display("** Error at %0t: o_instr_pop count = %0d, expected %0d",
					$time, pop_cnt - base_pop, n);
				err_cnt++;
			end
			if (retired_cnt - base_ret != n) begin
				$display("** Error at %0t: o_retire_valid count = %0d, expected %0d",
					$time, retired_cnt - base_ret, n);
				err_cnt++;
			end
		end
		report_test(name, base_err);
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_instr = '0;
		i_instr_empty = 1'b1;
		lfsr_state = 32'h6344;
		wr_idx = 0;
		rd_idx = 0;
		supplied = 0;
		pop_cnt = 0;
		retired_cnt = 0;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		gap_mode = 1'b0;
		timed_out = 1'b0;
		repeat (10) @(posedge CLK);
		i_rst_n <= 1'b1;
		check_idle();
		run_test("adder only", 0, 20);
		if (!timed_out) begin
			run_test("logic compare only", 1, 20);
		end
		if (!timed_out) begin
			run_test("interleaved", 2, 40);
		end
		if (!timed_out) begin
			run_test("burst", 3, 30);
		end
		if (!timed_out) begin
			run_test("input gaps", 4, 20);
		end
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* backend.f */
+incdir+verilog
verilog/backend_pkg.sv
verilog/issue_fifo.sv
verilog/dispatch.sv
verilog/adder_unit.sv
verilog/logcmp_unit.sv
verilog/reorder_commit.sv
verilog/backend.sv
testbench/backend_chk.sv
testbench/backend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= backend_tb
FILELIST ?= backend.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
